// ==== hdl/pcoeffPkg.sv ====
package pcoeffPkg;

    // Bot and top width
    localparam int BOT_WIDTH = 128;

    // Permutes per bot
    localparam int PERMUTE_COUNT = 6;

    // Batch totals
    localparam int COUNT_WIDTH = 10;
    localparam int SUM_WIDTH = COUNT_WIDTH + 35;

    // Queue sizes
    localparam int INPUT_DEPTH = 16;
    localparam int RESULT_DEPTH = 16;

    // Dispatcher, two lane stages and combiner sit between a pop and the results push
    localparam int RESULT_MARGIN = 4;

    // Lane arithmetic widths
    localparam int ONES_WIDTH = $clog2(BOT_WIDTH + 1);
    localparam int PERMUTE_POP_WIDTH = $clog2(PERMUTE_COUNT + 1);
    localparam int TERM_WIDTH = ONES_WIDTH + PERMUTE_POP_WIDTH;

    // A zero mask with lastBotOfBatch set is a pure batch marker
    typedef struct packed {
        logic [BOT_WIDTH-1:0] bot;
        logic [PERMUTE_COUNT-1:0] validPermutes;
        logic lastBotOfBatch;
    } botItem_t;

    typedef struct packed {
        logic [SUM_WIDTH-1:0] sum;
        logic [COUNT_WIDTH-1:0] count;
    } laneTotal_t;

    typedef struct packed {
        logic [SUM_WIDTH-1:0] pcoeffSum;
        logic [COUNT_WIDTH-1:0] pcoeffCount;
    } batchResult_t;

endpackage

// ==== hdl/syncFifo.sv ====
`timescale 1ns/1ns

module syncFifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 16,
    parameter int almostFullMargin = 0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t dataIn,
    input  logic     pop,
    output payload_t dataOut,
    output logic     empty,
    output logic     almostFull
);

    localparam int PTR_WIDTH = (depth > 1) ? $clog2(depth) : 1;
    localparam int FILL_WIDTH = $clog2(depth + 1);

    payload_t mem [depth];

    logic [PTR_WIDTH-1:0] rdPtr;
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [FILL_WIDTH-1:0] fill;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= dataIn;
        end
    end

    // Pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            fill <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_WIDTH'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_WIDTH'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Head is visible without a pop
    assign dataOut = mem[rdPtr];
    assign empty = (fill == '0);
    assign almostFull = (depth - int'(fill)) <= almostFullMargin;

    // Upstream flow control must keep us from overflowing
    overflowCheck: assert property (@(posedge clk) disable iff (rst)
        (push && !pop) |-> (int'(fill) < depth))
        else $error("syncFifo overflow");

    underflowCheck: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("syncFifo underflow");

endmodule

// ==== hdl/botDispatcher.sv ====
`timescale 1ns/1ns

module botDispatcher import pcoeffPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  botItem_t   head,
    input  logic       headPresent,
    input  logic       resultsAlmostFull,
    output logic       pop,
    output logic       creditReturn,
    output logic [1:0] laneValid,
    output botItem_t   laneBot,
    output logic       laneBatchEnd
);

    // Lane whose turn it is for the next valid bot
    logic turn;
    logic hasBot;

    // Results back-pressure holds items in the input FIFO
    assign pop = headPresent && !resultsAlmostFull;

    // Every popped item frees one input FIFO entry
    assign creditReturn = pop;

    assign hasBot = |head.validPermutes;

    always_ff @(posedge clk) begin
        if (rst) begin
            turn <= 1'b0;
            laneValid <= '0;
            laneBatchEnd <= 1'b0;
        end else begin
            laneValid <= '0;
            laneBatchEnd <= 1'b0;
            if (pop) begin
                // Batch end goes to both lanes at once
                laneBatchEnd <= head.lastBotOfBatch;
                if (hasBot) begin
                    laneValid[turn] <= 1'b1;
                    turn <= ~turn;
                end
            end
        end
    end

    // Shared bot bus, qualified per lane by laneValid
    always_ff @(posedge clk) begin
        if (pop) begin
            laneBot <= head;
        end
    end

endmodule

// ==== hdl/pcoeffLane.sv ====
`timescale 1ns/1ns

module pcoeffLane import pcoeffPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [BOT_WIDTH-1:0] top,
    input  logic                 botValid,
    input  botItem_t             botIn,
    input  logic                 batchEnd,
    output logic                 totalValid,
    output laneTotal_t           total
);

    // Stage one
    logic s1Valid;
    logic s1BatchEnd;
    logic [ONES_WIDTH-1:0] s1Ones;
    logic [PERMUTE_POP_WIDTH-1:0] s1Permutes;

    // Stage two
    logic [TERM_WIDTH-1:0] term;
    logic [SUM_WIDTH-1:0] runSum;
    logic [COUNT_WIDTH-1:0] runCount;
    logic [SUM_WIDTH-1:0] sumNext;
    logic [COUNT_WIDTH-1:0] countNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s1BatchEnd <= 1'b0;
        end else begin
            s1Valid <= botValid;
            s1BatchEnd <= batchEnd;
        end
    end

    // Popcounts of the overlap with top and of the permute mask
    always_ff @(posedge clk) begin
        if (botValid) begin
            s1Ones <= ONES_WIDTH'($countones(botIn.bot & top));
            s1Permutes <= PERMUTE_POP_WIDTH'($countones(botIn.validPermutes));
        end
    end

    // Running totals including the bot now in stage two
    always_comb begin
        term = TERM_WIDTH'(s1Ones) * TERM_WIDTH'(s1Permutes);
        sumNext = runSum;
        countNext = runCount;
        if (s1Valid) begin
            sumNext = runSum + SUM_WIDTH'(term);
            countNext = runCount + COUNT_WIDTH'(s1Permutes);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            runSum <= '0;
            runCount <= '0;
            totalValid <= 1'b0;
        end else begin
            totalValid <= s1BatchEnd;
            // Start the next batch from zero
            runSum <= s1BatchEnd ? '0 : sumNext;
            runCount <= s1BatchEnd ? '0 : countNext;
        end
    end

    always_ff @(posedge clk) begin
        if (s1BatchEnd) begin
            total.sum <= sumNext;
            total.count <= countNext;
        end
    end

    // Dispatcher never sends a bot with no valid permutes
    nonEmptyBot: assert property (@(posedge clk) disable iff (rst)
        botValid |-> (botIn.validPermutes != '0))
        else $error("pcoeffLane got a bot with an empty permute mask");

endmodule

// ==== hdl/batchCombiner.sv ====
`timescale 1ns/1ns

module batchCombiner import pcoeffPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         totalValidA,
    input  laneTotal_t   totalA,
    input  logic         totalValidB,
    input  laneTotal_t   totalB,
    output logic         resultValid,
    output batchResult_t result
);

    laneTotal_t maskedA;
    laneTotal_t maskedB;
    logic anyValid;

    // A lane without a strobe contributes nothing
    always_comb begin
        maskedA = totalValidA ? totalA : '0;
        maskedB = totalValidB ? totalB : '0;
    end

    assign anyValid = totalValidA || totalValidB;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= anyValid;
        end
    end

    always_ff @(posedge clk) begin
        if (anyValid) begin
            result.pcoeffSum <= maskedA.sum + maskedB.sum;
            result.pcoeffCount <= maskedA.count + maskedB.count;
        end
    end

    // Both lanes see every batch end in the same cycle and have equal depth
    lanesAligned: assert property (@(posedge clk) disable iff (rst)
        totalValidA == totalValidB)
        else $error("batchCombiner lane totals out of step");

endmodule

// ==== hdl/aggregatingPipelineTop.sv ====
`timescale 1ns/1ns

module aggregatingPipelineTop import pcoeffPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [BOT_WIDTH-1:0] top,
    input  logic                 itemValid,
    input  botItem_t             item,
    output logic                 creditReturn,
    input  logic                 grabResults,
    output logic                 resultsAvailable,
    output batchResult_t         result
);

    // Input FIFO to dispatcher
    botItem_t headItem;
    logic inputEmpty;
    logic headPresent;
    logic dispatchPop;

    // Dispatcher to lanes
    logic [1:0] laneValid;
    botItem_t laneBot;
    logic laneBatchEnd;

    // Lanes to combiner
    logic totalValidA;
    logic totalValidB;
    laneTotal_t totalA;
    laneTotal_t totalB;

    // Combiner to results FIFO
    logic resultValid;
    batchResult_t combinedResult;
    logic resultsAlmostFull;
    logic resultsEmpty;

    assign headPresent = !inputEmpty;
    assign resultsAvailable = !resultsEmpty;

    // Credits bound its occupancy, so almostFull is not needed
    syncFifo #(.payload_t(botItem_t), .depth(INPUT_DEPTH), .almostFullMargin(0)) inputFifo (
        .clk(clk), .rst(rst), .push(itemValid), .dataIn(item), .pop(dispatchPop),
        .dataOut(headItem), .empty(inputEmpty), .almostFull()
    );

    botDispatcher dispatcher (
        .clk(clk), .rst(rst), .head(headItem), .headPresent(headPresent),
        .resultsAlmostFull(resultsAlmostFull), .pop(dispatchPop), .creditReturn(creditReturn),
        .laneValid(laneValid), .laneBot(laneBot), .laneBatchEnd(laneBatchEnd)
    );

    pcoeffLane laneA (
        .clk(clk), .rst(rst), .top(top), .botValid(laneValid[0]), .botIn(laneBot),
        .batchEnd(laneBatchEnd), .totalValid(totalValidA), .total(totalA)
    );

    pcoeffLane laneB (
        .clk(clk), .rst(rst), .top(top), .botValid(laneValid[1]), .botIn(laneBot),
        .batchEnd(laneBatchEnd), .totalValid(totalValidB), .total(totalB)
    );

    batchCombiner combiner (
        .clk(clk), .rst(rst), .totalValidA(totalValidA), .totalA(totalA),
        .totalValidB(totalValidB), .totalB(totalB), .resultValid(resultValid),
        .result(combinedResult)
    );

    syncFifo #(
        .payload_t(batchResult_t), .depth(RESULT_DEPTH), .almostFullMargin(RESULT_MARGIN)
    ) resultsFifo (
        .clk(clk), .rst(rst), .push(resultValid), .dataIn(combinedResult), .pop(grabResults),
        .dataOut(result), .empty(resultsEmpty), .almostFull(resultsAlmostFull)
    );

endmodule

// ==== sim/aggregatingPipelineTb.sv ====
`timescale 1ns/1ns

module aggregatingPipelineTb import pcoeffPkg::*; ;

    // Longest test runs for a few thousand cycles at most
    localparam int CYCLE_LIMIT = 20000;

    logic clk;
    logic rst;
    logic [BOT_WIDTH-1:0] top;
    logic itemValid;
    botItem_t item;
    logic creditReturn;
    logic grabResults;
    logic resultsAvailable;
    batchResult_t result;

    integer seed = 32'hb4db1bbc;
    batchResult_t expected[$];
    botItem_t batchBuf[$];
    int itemsSent = 0;
    int creditsReturned = 0;
    int errorCount = 0;
    logic holdGrab = 1'b0;

    aggregatingPipelineTop dut_i (
        .clk(clk), .rst(rst), .top(top), .itemValid(itemValid), .item(item),
        .creditReturn(creditReturn), .grabResults(grabResults),
        .resultsAvailable(resultsAvailable), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic checkResult(input string name, input batchResult_t got,
                               input batchResult_t exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0t: %s got sum %0d count %0d, expected sum %0d count %0d",
                     $time, name, got.pcoeffSum, got.pcoeffCount,
                     exp.pcoeffSum, exp.pcoeffCount);
            failRun();
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp);
            failRun();
        end
    endtask

    // Sum of ones(bot & top) times valid permutes, and sum of valid permutes
    function automatic batchResult_t refResult(input botItem_t items[$],
                                               input logic [BOT_WIDTH-1:0] topVal);
        batchResult_t res;
        longint sum;
        int count;
        int ones;
        int permutes;
        sum = 0;
        count = 0;
        foreach (items[i]) begin
            ones = $countones(items[i].bot & topVal);
            permutes = $countones(items[i].validPermutes);
            sum += longint'(ones * permutes);
            count += permutes;
        end
        res.pcoeffSum = SUM_WIDTH'(sum);
        res.pcoeffCount = COUNT_WIDTH'(count);
        return res;
    endfunction

    task automatic addItem(input logic [BOT_WIDTH-1:0] bot,
                           input logic [PERMUTE_COUNT-1:0] mask, input logic last);
        botItem_t it;
        it.bot = bot;
        it.validPermutes = mask;
        it.lastBotOfBatch = last;
        batchBuf.push_back(it);
    endtask

    // Full mask, partial mask and a single permute on the last bot
    task automatic buildMixedBatch();
        batchBuf.delete();
        addItem(128'hff, 6'h3f, 1'b0);
        addItem({64'hffff_ffff_ffff_ffff, 64'h0f}, 6'b000101, 1'b0);
        addItem({128{1'b1}}, 6'b100000, 1'b1);
    endtask

    task automatic buildRandomBatch();
        int len;
        botItem_t it;
        batchBuf.delete();
        len = 1 + int'($unsigned($random(seed)) % 10);
        for (int i = 0; i < len; i++) begin
            it.bot = {$random(seed), $random(seed), $random(seed), $random(seed)};
            it.validPermutes = PERMUTE_COUNT'($random(seed));
            it.lastBotOfBatch = (i == len - 1);
            // Only the last item may be a bare marker
            if (it.validPermutes == '0 && !it.lastBotOfBatch) begin
                it.validPermutes = 6'h01;
            end
            batchBuf.push_back(it);
        end
    endtask

    // Waits while every credit is out
    task automatic driveItem(input botItem_t it);
        while (itemsSent - creditsReturned >= INPUT_DEPTH) begin
            @(posedge clk);
            #1;
        end
        itemValid = 1'b1;
        item = it;
        itemsSent++;
        @(posedge clk);
        #1;
        itemValid = 1'b0;
    endtask

    task automatic sendBatch(input botItem_t items[$]);
        expected.push_back(refResult(items, top));
        foreach (items[i]) begin
            driveItem(items[i]);
        end
    endtask

    task automatic waitIdle();
        while (expected.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    // Head of the results FIFO must not move while nobody reads
    task automatic watchHeldResults();
        batchResult_t heldHead;
        int highCycles;
        @(negedge clk);
        while (!resultsAvailable) begin
            @(negedge clk);
        end
        heldHead = result;
        highCycles = 0;
        while (highCycles < 200) begin
            @(negedge clk);
            checkResult("result during hold", result, heldHead);
            highCycles++;
        end
        holdGrab = 1'b0;
    endtask

    // Result reader
    initial begin
        batchResult_t expHead;
        grabResults = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && resultsAvailable && !holdGrab) begin
                if (expected.size() == 0) begin
                    $display("A result arrived at %0t with no batch outstanding", $time);
                    failRun();
                end
                expHead = expected.pop_front();
                checkResult("result", result, expHead);
                grabResults = 1'b1;
            end else begin
                grabResults = 1'b0;
            end
        end
    end

    // Credit returns, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && creditReturn) begin
                if (itemsSent == 0) begin
                    $display("creditReturn pulsed at %0t before any item was sent", $time);
                    failRun();
                end else begin
                    creditsReturned++;
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                failRun();
            end
        end
    end

    initial begin
        rst = 1'b1;
        itemValid = 1'b0;
        item = '0;
        top = {64'h0, 64'hffff_ffff_ffff_ffff};
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1;

        // Hand-chosen bots
        buildMixedBatch();
        sendBatch(batchBuf);
        waitIdle();

        // Marker-only batch, then a batch ending on a bot
        batchBuf.delete();
        addItem(128'h0, 6'h00, 1'b1);
        sendBatch(batchBuf);
        batchBuf.delete();
        addItem(128'hf0f0, 6'h03, 1'b0);
        addItem(128'h1_0000_0001, 6'h3f, 1'b1);
        sendBatch(batchBuf);
        waitIdle();

        // Back-to-back random batches
        for (int i = 0; i < 100; i++) begin
            buildRandomBatch();
            sendBatch(batchBuf);
        end
        waitIdle();

        // Reader stalls until results have sat for a while
        holdGrab = 1'b1;
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    buildRandomBatch();
                    sendBatch(batchBuf);
                end
            end
            watchHeldResults();
        join
        waitIdle();

        // Same bots against different tops
        top = ~top;
        buildMixedBatch();
        sendBatch(batchBuf);
        waitIdle();
        top = {$random(seed), $random(seed), $random(seed), $random(seed)};
        buildMixedBatch();
        sendBatch(batchBuf);
        waitIdle();

        checkCount("creditReturn pulses", creditsReturned, itemsSent);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== aggregatingPipelineTop.f ====
hdl/pcoeffPkg.sv
hdl/syncFifo.sv
hdl/botDispatcher.sv
hdl/pcoeffLane.sv
hdl/batchCombiner.sv
hdl/aggregatingPipelineTop.sv
sim/aggregatingPipelineTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the aggregating pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --assert -Wno-fatal \
    --top-module aggregatingPipelineTb \
    --Mdir "$BUILD_DIR" -o simv \
    -f aggregatingPipelineTop.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/simv" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0
